//--- rtl/af_delay_regs.sv
`default_nettype none

module af_delay_regs #(
	parameter int N_AF_WORDS = 2
) (
	input  wire logic                                control_clk,
	input  wire logic                                rst_i,
	input  wire logic                                cs_i,
	input  wire logic                                we_i,
	input  wire logic [emtf_regbank_pkg::ADDR_W-1:0] reg_addr_i,
	input  wire logic [emtf_regbank_pkg::DATA_W-1:0] wdata_i,
	output logic [N_AF_WORDS*emtf_regbank_pkg::AF_PER_WORD*
		emtf_regbank_pkg::AF_DELAY_W-1:0]            af_delays_o
);
	import emtf_regbank_pkg::*;

	localparam int WORD_W = AF_PER_WORD * AF_DELAY_W;

	logic [WORD_W-1:0] delay_q [N_AF_WORDS];

	always_ff @(posedge control_clk) begin
		for (int k = 0; k < N_AF_WORDS; k++) begin
			if (rst_i) begin
				delay_q[k] <= {AF_PER_WORD{AF_DELAY_DEFAULT}};
			end else if (cs_i && we_i && reg_addr_i == ADDR_AF + ADDR_W'(k)) begin
				delay_q[k] <= wdata_i[WORD_W-1:0];
			end
		end
	end

	// chamber 8k+j from byte j of word k
	for (genvar k = 0; k < N_AF_WORDS; k++) begin : g_word
		for (genvar j = 0; j < AF_PER_WORD; j++) begin : g_chamber
			assign af_delays_o[(k*AF_PER_WORD+j)*AF_DELAY_W +: AF_DELAY_W] =
				delay_q[k][j*AF_DELAY_W +: AF_DELAY_W];
		end
	end

endmodule

`default_nettype wire

//--- rtl/config_regs.sv
`default_nettype none

module config_regs (
	input  wire logic                                control_clk,
	input  wire logic                                rst_i,
	input  wire logic                                cs_i,
	input  wire logic                                we_i,
	input  wire logic [emtf_regbank_pkg::ADDR_W-1:0] reg_addr_i,
	input  wire logic [emtf_regbank_pkg::DATA_W-1:0] wdata_i,
	input  wire logic                                pt_busy_i,
	input  wire logic [7:0]                          delayctrl_locked_i,
	output logic [emtf_regbank_pkg::DATA_W-1:0]      control_reg_o,
	output logic [emtf_regbank_pkg::DATA_W-1:0]      fiber_enable_o,
	output emtf_regbank_pkg::misc_cfg_u              misc_cfg_o,
	output emtf_regbank_pkg::misc_cfg_u              misc_rb_o,
	output logic [emtf_regbank_pkg::DATA_W-1:0]      hr_to_o
);
	import emtf_regbank_pkg::*;

	logic [HR_TO_W-1:0] hard_reset_to_q;
	logic [HR_TO_W-1:0] mpc_hr_to_q;
	misc_cfg_u          misc_wr;
	logic               wr_en;

	assign wr_en   = cs_i && we_i;
	assign hr_to_o = {{(DATA_W-2*HR_TO_W){1'b0}}, mpc_hr_to_q, hard_reset_to_q};

	// host word with read-only and reserved bits dropped
	always_comb begin
		misc_wr.raw                = wdata_i;
		misc_wr.f.pt_busy          = 1'b0;
		misc_wr.f.delayctrl_locked = '0;
		misc_wr.f.rsv_lo           = '0;
		misc_wr.f.rsv_hi           = '0;
	end

	// status bits go in live on readback
	always_comb begin
		misc_rb_o                    = misc_cfg_o;
		misc_rb_o.f.pt_busy          = pt_busy_i;
		misc_rb_o.f.delayctrl_locked = delayctrl_locked_i;
	end

	//////////////////////////////
	// writable registers
	//////////////////////////////
	always_ff @(posedge control_clk) begin
		if (rst_i) begin
			control_reg_o                  <= CTRL_DEFAULT;
			fiber_enable_o                 <= FIBER_DEFAULT;
			hard_reset_to_q                <= HARD_RESET_TO_DEFAULT;
			mpc_hr_to_q                    <= MPC_HR_TO_DEFAULT;
			misc_cfg_o                     <= '0;
			misc_cfg_o.f.ttc_bc0_delay     <= 9'd86;
			misc_cfg_o.f.ttc_bc0_delay_cppf <= 6'd36;
			misc_cfg_o.f.daq_delay         <= 9'd256;
			misc_cfg_o.f.spy_l1a           <= 1'b1;
			misc_cfg_o.f.af_enable         <= 1'b1;
			misc_cfg_o.f.spy_bc0_err       <= 1'b1;
		end else if (wr_en) begin
			case (reg_addr_i)
				ADDR_CTRL: begin
					control_reg_o <= wdata_i;
				end
				ADDR_FIBER: begin
					fiber_enable_o <= wdata_i;
				end
				ADDR_MISC: begin
					misc_cfg_o <= misc_wr;
				end
				ADDR_HR_TO: begin
					hard_reset_to_q <= wdata_i[HR_TO_W-1:0];
					mpc_hr_to_q     <= wdata_i[2*HR_TO_W-1:HR_TO_W];
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/emtf_regbank_pkg.sv
`default_nettype none

package emtf_regbank_pkg;

	// widths
	localparam int DATA_W         = 64;
	localparam int ADDR_W         = 9;
	localparam int LINK_ID_W      = 10;
	localparam int LINKS_PER_WORD = 6;
	localparam int AF_DELAY_W     = 8;
	localparam int AF_PER_WORD    = 8;
	localparam int RATE_W         = 26;
	localparam int RATE_TAG_W     = 6;
	localparam int HR_TO_W        = 24;

	//////////////////////////////
	// address map
	//////////////////////////////
	localparam logic [ADDR_W-1:0] ADDR_CTRL    = 9'h000;
	localparam logic [ADDR_W-1:0] ADDR_LINK_ID = 9'h001;
	localparam logic [ADDR_W-1:0] ADDR_FIBER   = 9'h00b;
	localparam logic [ADDR_W-1:0] ADDR_AF      = 9'h00c;
	localparam logic [ADDR_W-1:0] ADDR_MISC    = 9'h011;
	localparam logic [ADDR_W-1:0] ADDR_RATE    = 9'h033;
	localparam logic [ADDR_W-1:0] ADDR_HR_TO   = 9'h056;

	// reset values
	localparam logic [DATA_W-1:0]     CTRL_DEFAULT          = 64'h0000_0000_0008_0000;
	localparam logic [DATA_W-1:0]     FIBER_DEFAULT         = 64'h00ff_ffff_ffff_ffff;
	localparam logic [AF_DELAY_W-1:0] AF_DELAY_DEFAULT      = 8'd1;
	// 3700 orbits of 3564 bx
	localparam logic [HR_TO_W-1:0]    HARD_RESET_TO_DEFAULT = 24'd13186800;
	localparam logic [HR_TO_W-1:0]    MPC_HR_TO_DEFAULT     = 24'd4000000;

	// misc word, msb first
	typedef struct packed {
		logic [2:0]  rsv_hi;
		logic [5:0]  ttc_bc0_delay_cppf;
		logic [11:0] bxn_tx_offset;
		logic [8:0]  ttc_bc0_delay;
		logic [2:0]  prbs_sel;
		logic        mpc_inj_enable;
		logic [7:0]  delayctrl_locked;
		logic        pt_busy;
		logic        inj_enable;
		logic        af_enable;
		logic        spy_rank;
		logic        spy_valid;
		logic        spy_l1a;
		logic [8:0]  daq_delay;
		logic [1:0]  rsv_lo;
		logic        spy_bc0_err;
		logic [2:0]  sector;
		logic        endcap;
	} misc_cfg_t;

	typedef union packed {
		logic [DATA_W-1:0] raw;
		misc_cfg_t         f;
	} misc_cfg_u;

endpackage

`default_nettype wire

//--- rtl/emtf_regbank_top.sv
`default_nettype none

module emtf_regbank_top #(
	parameter int N_LINK_WORDS = 2,
	parameter int N_AF_WORDS   = 2,
	parameter int N_RATE_WORDS = 4
) (
	input  wire logic                                control_clk,
	input  wire logic                                rst_i,
	input  wire logic                                cs_i,
	input  wire logic                                we_i,
	input  wire logic [1:0]                          sel_i,
	input  wire logic [6:0]                          addr_i,
	input  wire logic [emtf_regbank_pkg::DATA_W-1:0] wdata_i,
	input  wire logic                                pt_busy_i,
	input  wire logic [7:0]                          delayctrl_locked_i,
	input  wire logic [N_LINK_WORDS*emtf_regbank_pkg::LINKS_PER_WORD*
			emtf_regbank_pkg::LINK_ID_W-1:0]         link_id_i,
	input  wire logic [N_AF_WORDS*emtf_regbank_pkg::AF_PER_WORD*
			emtf_regbank_pkg::AF_DELAY_W-1:0]        bc0_time_counts_i,
	input  wire logic [2*N_RATE_WORDS*emtf_regbank_pkg::RATE_W-1:0] rates_i,
	output logic [emtf_regbank_pkg::DATA_W-1:0]      rdata_o,
	output logic [emtf_regbank_pkg::DATA_W-1:0]      control_reg_o,
	output logic [emtf_regbank_pkg::DATA_W-1:0]      fiber_enable_o,
	output emtf_regbank_pkg::misc_cfg_u              misc_cfg_o,
	output logic [emtf_regbank_pkg::HR_TO_W-1:0]     hard_reset_to_o,
	output logic [emtf_regbank_pkg::HR_TO_W-1:0]     mpc_link_hr_to_o,
	output logic [N_AF_WORDS*emtf_regbank_pkg::AF_PER_WORD*
			emtf_regbank_pkg::AF_DELAY_W-1:0]        af_delays_o
);
	import emtf_regbank_pkg::*;

	logic [ADDR_W-1:0]              reg_addr;
	misc_cfg_u                      misc_rb;
	logic [DATA_W-1:0]              hr_to;
	logic [N_LINK_WORDS*DATA_W-1:0] link_words;
	logic [N_AF_WORDS*DATA_W-1:0]   bc0_words;
	logic [N_RATE_WORDS*DATA_W-1:0] rate_words;

	assign reg_addr         = {sel_i, addr_i};
	assign hard_reset_to_o  = hr_to[HR_TO_W-1:0];
	assign mpc_link_hr_to_o = hr_to[2*HR_TO_W-1:HR_TO_W];

	config_regs i_config_regs (
		.control_clk        (control_clk),
		.rst_i              (rst_i),
		.cs_i               (cs_i),
		.we_i               (we_i),
		.reg_addr_i         (reg_addr),
		.wdata_i            (wdata_i),
		.pt_busy_i          (pt_busy_i),
		.delayctrl_locked_i (delayctrl_locked_i),
		.control_reg_o      (control_reg_o),
		.fiber_enable_o     (fiber_enable_o),
		.misc_cfg_o         (misc_cfg_o),
		.misc_rb_o          (misc_rb),
		.hr_to_o            (hr_to)
	);

	af_delay_regs #(.N_AF_WORDS(N_AF_WORDS)) i_af_delay_regs (
		.control_clk (control_clk),
		.rst_i       (rst_i),
		.cs_i        (cs_i),
		.we_i        (we_i),
		.reg_addr_i  (reg_addr),
		.wdata_i     (wdata_i),
		.af_delays_o (af_delays_o)
	);

	status_pack #(
		.N_LINK_WORDS (N_LINK_WORDS),
		.N_AF_WORDS   (N_AF_WORDS),
		.N_RATE_WORDS (N_RATE_WORDS)
	) i_status_pack (
		.link_id_i         (link_id_i),
		.bc0_time_counts_i (bc0_time_counts_i),
		.rates_i           (rates_i),
		.link_words_o      (link_words),
		.bc0_words_o       (bc0_words),
		.rate_words_o      (rate_words)
	);

	read_mux #(
		.N_LINK_WORDS (N_LINK_WORDS),
		.N_AF_WORDS   (N_AF_WORDS),
		.N_RATE_WORDS (N_RATE_WORDS)
	) i_read_mux (
		.control_clk    (control_clk),
		.rst_i          (rst_i),
		.cs_i           (cs_i),
		.reg_addr_i     (reg_addr),
		.control_reg_i  (control_reg_o),
		.fiber_enable_i (fiber_enable_o),
		.misc_rb_i      (misc_rb),
		.hr_to_i        (hr_to),
		.link_words_i   (link_words),
		.bc0_words_i    (bc0_words),
		.rate_words_i   (rate_words),
		.rdata_o        (rdata_o)
	);

endmodule

`default_nettype wire

//--- rtl/read_mux.sv
`default_nettype none

module read_mux #(
	parameter int N_LINK_WORDS = 2,
	parameter int N_AF_WORDS   = 2,
	parameter int N_RATE_WORDS = 4
) (
	input  wire logic                                             control_clk,
	input  wire logic                                             rst_i,
	input  wire logic                                             cs_i,
	input  wire logic [emtf_regbank_pkg::ADDR_W-1:0]              reg_addr_i,
	input  wire logic [emtf_regbank_pkg::DATA_W-1:0]              control_reg_i,
	input  wire logic [emtf_regbank_pkg::DATA_W-1:0]              fiber_enable_i,
	input  wire emtf_regbank_pkg::misc_cfg_u                      misc_rb_i,
	input  wire logic [emtf_regbank_pkg::DATA_W-1:0]              hr_to_i,
	input  wire logic [N_LINK_WORDS*emtf_regbank_pkg::DATA_W-1:0] link_words_i,
	input  wire logic [N_AF_WORDS*emtf_regbank_pkg::DATA_W-1:0]   bc0_words_i,
	input  wire logic [N_RATE_WORDS*emtf_regbank_pkg::DATA_W-1:0] rate_words_i,
	output logic [emtf_regbank_pkg::DATA_W-1:0]                   rdata_o
);
	import emtf_regbank_pkg::*;

	logic [DATA_W-1:0] rd_word;

	// decode, zero for unmapped or idle
	always_comb begin
		rd_word = '0;
		if (cs_i) begin
			case (reg_addr_i)
				ADDR_CTRL:  rd_word = control_reg_i;
				ADDR_FIBER: rd_word = fiber_enable_i;
				ADDR_MISC:  rd_word = misc_rb_i.raw;
				ADDR_HR_TO: rd_word = hr_to_i;
				default:    rd_word = '0;
			endcase
			for (int k = 0; k < N_LINK_WORDS; k++) begin
				if (reg_addr_i == ADDR_LINK_ID + ADDR_W'(k))
					rd_word = link_words_i[k*DATA_W +: DATA_W];
			end
			// delay addresses read back measured bc0 times
			for (int k = 0; k < N_AF_WORDS; k++) begin
				if (reg_addr_i == ADDR_AF + ADDR_W'(k))
					rd_word = bc0_words_i[k*DATA_W +: DATA_W];
			end
			for (int k = 0; k < N_RATE_WORDS; k++) begin
				if (reg_addr_i == ADDR_RATE + ADDR_W'(k))
					rd_word = rate_words_i[k*DATA_W +: DATA_W];
			end
		end
	end

	always_ff @(posedge control_clk) begin
		if (rst_i) begin
			rdata_o <= '0;
		end else begin
			rdata_o <= rd_word;
		end
	end

endmodule

`default_nettype wire

//--- rtl/status_pack.sv
`default_nettype none

module status_pack #(
	parameter int N_LINK_WORDS = 2,
	parameter int N_AF_WORDS   = 2,
	parameter int N_RATE_WORDS = 4
) (
	input  wire logic [N_LINK_WORDS*emtf_regbank_pkg::LINKS_PER_WORD*
		emtf_regbank_pkg::LINK_ID_W-1:0]                            link_id_i,
	input  wire logic [N_AF_WORDS*emtf_regbank_pkg::AF_PER_WORD*
		emtf_regbank_pkg::AF_DELAY_W-1:0]                           bc0_time_counts_i,
	input  wire logic [2*N_RATE_WORDS*emtf_regbank_pkg::RATE_W-1:0] rates_i,
	output logic [N_LINK_WORDS*emtf_regbank_pkg::DATA_W-1:0]        link_words_o,
	output logic [N_AF_WORDS*emtf_regbank_pkg::DATA_W-1:0]          bc0_words_o,
	output logic [N_RATE_WORDS*emtf_regbank_pkg::DATA_W-1:0]        rate_words_o
);
	import emtf_regbank_pkg::*;

	localparam int LINK_BITS  = LINKS_PER_WORD * LINK_ID_W;
	localparam int LINK_PAD_W = DATA_W - LINK_BITS;
	localparam int RATE_PAD_W = DATA_W/2 - RATE_W;

	//////////////////////////////
	// link ids, 6 per word
	//////////////////////////////
	for (genvar k = 0; k < N_LINK_WORDS; k++) begin : g_link
		for (genvar j = 0; j < LINKS_PER_WORD; j++) begin : g_id
			assign link_words_o[k*DATA_W + j*LINK_ID_W +: LINK_ID_W] =
				link_id_i[(k*LINKS_PER_WORD+j)*LINK_ID_W +: LINK_ID_W];
		end
		assign link_words_o[k*DATA_W + LINK_BITS +: LINK_PAD_W] = '0;
	end

	// bc0 time counts, byte j of word k
	for (genvar k = 0; k < N_AF_WORDS; k++) begin : g_bc0
		for (genvar j = 0; j < AF_PER_WORD; j++) begin : g_cnt
			assign bc0_words_o[k*DATA_W + j*AF_DELAY_W +: AF_DELAY_W] =
				bc0_time_counts_i[(k*AF_PER_WORD+j)*AF_DELAY_W +: AF_DELAY_W];
		end
	end

	//////////////////////////////
	// rates, two per word plus tag
	//////////////////////////////
	for (genvar k = 0; k < N_RATE_WORDS; k++) begin : g_rate
		assign rate_words_o[k*DATA_W +: DATA_W] = {
			RATE_TAG_W'(k),
			rates_i[(2*k+1)*RATE_W +: RATE_W],
			{RATE_PAD_W{1'b0}},
			rates_i[2*k*RATE_W +: RATE_W]
		};
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the register bank testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module emtf_regbank_tb \
	-f src.f -o emtf_regbank_sim > sim.log 2>&1 &&
	./obj_dir/emtf_regbank_sim >> sim.log 2>&1 ||
	echo "build or simulation returned an error" >> sim.log
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- src.f
rtl/emtf_regbank_pkg.sv
rtl/config_regs.sv
rtl/af_delay_regs.sv
rtl/status_pack.sv
rtl/read_mux.sv
rtl/emtf_regbank_top.sv
verif/emtf_regbank_assertions.sv
verif/emtf_regbank_checker.sv
verif/emtf_regbank_tb.sv

//--- verif/emtf_regbank_assertions.sv
`default_nettype none

module emtf_regbank_assertions (
	input wire logic                                control_clk,
	input wire logic                                rst_i,
	input wire logic                                cs_i,
	input wire logic [emtf_regbank_pkg::DATA_W-1:0] rdata_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// no request, no data on the next cycle
	idle_read_zero: assert property (@(posedge control_clk) disable iff (rst_i)
		!cs_i |=> rdata_i == '0)
		else $error("rdata_o not zero after a cycle with cs_i low");

	reset_read_zero: assert property (@(posedge control_clk)
		rst_i |=> rdata_i == '0)
		else $error("rdata_o not zero after a reset cycle");

endmodule

bind read_mux emtf_regbank_assertions i_read_assertions (
	.control_clk (control_clk),
	.rst_i       (rst_i),
	.cs_i        (cs_i),
	.rdata_i     (rdata_o)
);

`default_nettype wire

//--- verif/emtf_regbank_checker.sv
`default_nettype none

module emtf_regbank_checker #(
	parameter int AF_BITS  = 128,
	parameter int CFG_BITS = 240
) (
	input  wire logic                control_clk,
	input  wire logic                active_i,
	input  wire logic                chk_i,
	input  wire logic [63:0]         exp_rdata_i,
	input  wire logic [AF_BITS-1:0]  exp_af_i,
	input  wire logic [CFG_BITS-1:0] exp_cfg_i,
	input  wire logic [63:0]         rdata_i,
	input  wire logic [AF_BITS-1:0]  af_delays_i,
	input  wire logic [63:0]         control_reg_i,
	input  wire logic [63:0]         fiber_enable_i,
	input  wire logic [63:0]         misc_cfg_i,
	input  wire logic [23:0]         hard_reset_to_i,
	input  wire logic [23:0]         mpc_link_hr_to_i,
	output int                       err_count_o,
	output int                       check_count_o
);
	timeunit 1ns;
	timeprecision 1ps;

	int err_count = 0;
	int check_count = 0;

	assign err_count_o   = err_count;
	assign check_count_o = check_count;

	task automatic compare_word(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		check_count++;
		if (act_v !== exp_v) begin
			err_count++;
			$display("Error at %0t: %s expected %h, actual %h",
				$time, name, exp_v, act_v);
		end
	endtask

	always @(negedge control_clk) begin
		if (active_i && chk_i) begin
			compare_word("rdata_o", exp_rdata_i, rdata_i);
		end
		// configuration and delay outputs are compared every active cycle
		if (active_i) begin
			check_count++;
			if (af_delays_i !== exp_af_i) begin
				err_count++;
				$display("Error at %0t: af_delays_o expected %h, actual %h",
					$time, exp_af_i, af_delays_i);
			end
			compare_word("control_reg_o", exp_cfg_i[239:176], control_reg_i);
			compare_word("fiber_enable_o", exp_cfg_i[175:112], fiber_enable_i);
			compare_word("misc_cfg_o", exp_cfg_i[111:48], misc_cfg_i);
			compare_word("mpc_link_hr_to_o", exp_cfg_i[47:24], mpc_link_hr_to_i);
			compare_word("hard_reset_to_o", exp_cfg_i[23:0], hard_reset_to_i);
		end
	end

endmodule

`default_nettype wire

//--- verif/emtf_regbank_tb.sv
`default_nettype none

module emtf_regbank_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import emtf_regbank_pkg::*;

	localparam int N_LINK_WORDS = 2;
	localparam int N_AF_WORDS   = 2;
	localparam int N_RATE_WORDS = 4;
	localparam int AF_BITS      = N_AF_WORDS * 64;
	localparam int CFG_BITS     = 3*64 + 48;

	logic                         control_clk;
	logic                         rst_i;
	logic                         cs_i;
	logic                         we_i;
	logic [1:0]                   sel_i;
	logic [6:0]                   addr_i;
	logic [63:0]                  wdata_i;
	logic                         pt_busy_i;
	logic [7:0]                   delayctrl_locked_i;
	logic [N_LINK_WORDS*60-1:0]   link_id_i;
	logic [AF_BITS-1:0]           bc0_time_counts_i;
	logic [N_RATE_WORDS*52-1:0]   rates_i;
	logic [63:0]                  rdata_o;
	logic [63:0]                  control_reg_o;
	logic [63:0]                  fiber_enable_o;
	misc_cfg_u                    misc_cfg_o;
	logic [23:0]                  hard_reset_to_o;
	logic [23:0]                  mpc_link_hr_to_o;
	logic [AF_BITS-1:0]           af_delays_o;

	// random status values, one entry per id or counter
	logic [9:0]  link_ids [N_LINK_WORDS*6];
	logic [7:0]  bc0_counts [N_AF_WORDS*8];
	logic [25:0] rates [N_RATE_WORDS*2];

	//////////////////////////////
	// stimulus table
	//////////////////////////////
	bit                  tbl_cs [$];
	bit                  tbl_we [$];
	logic [8:0]          tbl_addr [$];
	logic [63:0]         tbl_wdata [$];
	logic [63:0]         tbl_exp [$];
	bit                  tbl_chk [$];
	logic [AF_BITS-1:0]  tbl_af [$];
	logic [CFG_BITS-1:0] tbl_cfg [$];
	logic [AF_BITS-1:0]  af_model;
	logic [63:0]         ctrl_model;
	logic [63:0]         fiber_model;
	misc_cfg_u           misc_model;
	logic [47:0]         hr_model;

	logic                active;
	logic                chk;
	logic [63:0]         exp_rdata;
	logic [AF_BITS-1:0]  exp_af;
	logic [CFG_BITS-1:0] exp_cfg;
	int                  err_count;
	int                  check_count;
	int                  cycle_count = 0;
	int                  max_cycles = 1000;
	int unsigned         seed_ret;

	initial begin
		control_clk = 1'b0;
		forever #50 control_clk = ~control_clk;
	end

	emtf_regbank_top #(
		.N_LINK_WORDS (N_LINK_WORDS),
		.N_AF_WORDS   (N_AF_WORDS),
		.N_RATE_WORDS (N_RATE_WORDS)
	) i_dut (
		.control_clk        (control_clk),
		.rst_i              (rst_i),
		.cs_i               (cs_i),
		.we_i               (we_i),
		.sel_i              (sel_i),
		.addr_i             (addr_i),
		.wdata_i            (wdata_i),
		.pt_busy_i          (pt_busy_i),
		.delayctrl_locked_i (delayctrl_locked_i),
		.link_id_i          (link_id_i),
		.bc0_time_counts_i  (bc0_time_counts_i),
		.rates_i            (rates_i),
		.rdata_o            (rdata_o),
		.control_reg_o      (control_reg_o),
		.fiber_enable_o     (fiber_enable_o),
		.misc_cfg_o         (misc_cfg_o),
		.hard_reset_to_o    (hard_reset_to_o),
		.mpc_link_hr_to_o   (mpc_link_hr_to_o),
		.af_delays_o        (af_delays_o)
	);

	emtf_regbank_checker #(
		.AF_BITS  (AF_BITS),
		.CFG_BITS (CFG_BITS)
	) i_checker (
		.control_clk      (control_clk),
		.active_i         (active),
		.chk_i            (chk),
		.exp_rdata_i      (exp_rdata),
		.exp_af_i         (exp_af),
		.exp_cfg_i        (exp_cfg),
		.rdata_i          (i_dut.rdata_o),
		.af_delays_i      (i_dut.af_delays_o),
		.control_reg_i    (i_dut.control_reg_o),
		.fiber_enable_i   (i_dut.fiber_enable_o),
		.misc_cfg_i       (i_dut.misc_cfg_o),
		.hard_reset_to_i  (i_dut.hard_reset_to_o),
		.mpc_link_hr_to_i (i_dut.mpc_link_hr_to_o),
		.err_count_o      (err_count),
		.check_count_o    (check_count)
	);

	function automatic logic [63:0] pack_link_word(input int k);
		logic [63:0] w;
		w = '0;
		for (int j = 0; j < 6; j++) begin
			w[10*j +: 10] = link_ids[6*k + j];
		end
		return w;
	endfunction

	function automatic logic [63:0] pack_bc0_word(input int k);
		logic [63:0] w;
		for (int j = 0; j < 8; j++) begin
			w[8*j +: 8] = bc0_counts[8*k + j];
		end
		return w;
	endfunction

	function automatic logic [63:0] pack_rate_word(input int k);
		logic [63:0] w;
		w = '0;
		w[63:58] = 6'(k);
		w[57:32] = rates[2*k + 1];
		w[25:0]  = rates[2*k];
		return w;
	endfunction

	task automatic add_entry(input bit cs, input bit we, input logic [8:0] addr,
			input logic [63:0] wdata, input logic [63:0] exp, input bit chk_en);
		tbl_cs.push_back(cs);
		tbl_we.push_back(we);
		tbl_addr.push_back(addr);
		tbl_wdata.push_back(wdata);
		tbl_exp.push_back(exp);
		tbl_chk.push_back(chk_en);
		tbl_af.push_back(af_model);
		tbl_cfg.push_back({ctrl_model, fiber_model, misc_model.raw, hr_model});
	endtask

	task automatic build_table();
		misc_cfg_u   misc_exp;
		logic [63:0] ctrl_def;
		logic [63:0] fiber_def;
		logic [63:0] hr_def;
		logic [63:0] c1;
		logic [63:0] f1;
		logic [63:0] h1;
		logic [63:0] d;
		ctrl_def  = 64'h0000_0000_0008_0000;
		fiber_def = 64'h00ff_ffff_ffff_ffff;
		hr_def    = {16'h0, 24'd4000000, 24'd13186800};
		c1        = {$urandom(), $urandom()};
		f1        = {$urandom(), $urandom()};
		h1        = {$urandom(), $urandom()};
		misc_exp.raw                = '0;
		misc_exp.f.ttc_bc0_delay      = 9'd86;
		misc_exp.f.ttc_bc0_delay_cppf = 6'd36;
		misc_exp.f.daq_delay          = 9'd256;
		misc_exp.f.spy_l1a            = 1'b1;
		misc_exp.f.af_enable          = 1'b1;
		misc_exp.f.spy_bc0_err        = 1'b1;
		misc_exp.f.pt_busy            = pt_busy_i;
		misc_exp.f.delayctrl_locked   = delayctrl_locked_i;
		ctrl_model  = ctrl_def;
		fiber_model = fiber_def;
		hr_model    = hr_def[47:0];
		misc_model  = misc_exp;
		misc_model.f.pt_busy          = 1'b0;
		misc_model.f.delayctrl_locked = '0;
		af_model = {N_AF_WORDS*8{8'h01}};
		add_entry(1'b1, 1'b0, ADDR_CTRL, '0, ctrl_def, 1'b1);
		add_entry(1'b1, 1'b0, ADDR_FIBER, '0, fiber_def, 1'b1);
		add_entry(1'b1, 1'b0, ADDR_MISC, '0, misc_exp.raw, 1'b1);
		add_entry(1'b1, 1'b0, ADDR_HR_TO, '0, hr_def, 1'b1);
		// a write reads back the old word in its own cycle
		ctrl_model = c1;
		add_entry(1'b1, 1'b1, ADDR_CTRL, c1, ctrl_def, 1'b1);
		add_entry(1'b1, 1'b0, ADDR_CTRL, '0, c1, 1'b1);
		fiber_model = f1;
		add_entry(1'b1, 1'b1, ADDR_FIBER, f1, fiber_def, 1'b1);
		add_entry(1'b1, 1'b0, ADDR_FIBER, '0, f1, 1'b1);
		hr_model = h1[47:0];
		add_entry(1'b1, 1'b1, ADDR_HR_TO, h1, hr_def, 1'b1);
		add_entry(1'b1, 1'b0, ADDR_HR_TO, '0, {16'h0, h1[47:0]}, 1'b1);
		// stored word drops read-only and reserved bits
		misc_model.raw                = '1;
		misc_model.f.rsv_lo           = '0;
		misc_model.f.rsv_hi           = '0;
		misc_model.f.pt_busy          = 1'b0;
		misc_model.f.delayctrl_locked = '0;
		add_entry(1'b1, 1'b1, ADDR_MISC, '1, misc_exp.raw, 1'b1);
		misc_exp                    = misc_model;
		misc_exp.f.pt_busy          = pt_busy_i;
		misc_exp.f.delayctrl_locked = delayctrl_locked_i;
		add_entry(1'b1, 1'b0, ADDR_MISC, '0, misc_exp.raw, 1'b1);
		for (int k = 0; k < N_AF_WORDS; k++) begin
			d = {$urandom(), $urandom()};
			af_model[64*k +: 64] = d;
			add_entry(1'b1, 1'b1, ADDR_AF + 9'(k), d, pack_bc0_word(k), 1'b1);
			add_entry(1'b1, 1'b0, ADDR_AF + 9'(k), '0, pack_bc0_word(k), 1'b1);
		end
		add_entry(1'b1, 1'b0, ADDR_AF + 9'(N_AF_WORDS), '0, '0, 1'b1);
		for (int k = 0; k < N_LINK_WORDS; k++) begin
			add_entry(1'b1, 1'b0, ADDR_LINK_ID + 9'(k), '0, pack_link_word(k), 1'b1);
		end
		add_entry(1'b1, 1'b0, ADDR_LINK_ID + 9'(N_LINK_WORDS), '0, '0, 1'b1);
		for (int k = 0; k < N_RATE_WORDS; k++) begin
			add_entry(1'b1, 1'b0, ADDR_RATE + 9'(k), '0, pack_rate_word(k), 1'b1);
		end
		add_entry(1'b1, 1'b0, ADDR_RATE + 9'(N_RATE_WORDS), '0, '0, 1'b1);
		// unmapped, idle, and a write with cs low
		add_entry(1'b1, 1'b0, 9'h00a, '0, '0, 1'b1);
		add_entry(1'b1, 1'b0, 9'h100, '0, '0, 1'b1);
		add_entry(1'b0, 1'b0, ADDR_CTRL, '0, '0, 1'b1);
		add_entry(1'b0, 1'b1, ADDR_CTRL, ~c1, '0, 1'b1);
		add_entry(1'b1, 1'b0, ADDR_CTRL, '0, c1, 1'b1);
	endtask

	initial begin
		rst_i     = 1'b1;
		cs_i      = 1'b0;
		we_i      = 1'b0;
		sel_i     = '0;
		addr_i    = '0;
		wdata_i   = '0;
		active    = 1'b0;
		chk       = 1'b0;
		exp_rdata = '0;
		exp_af    = '0;
		exp_cfg   = '0;
		seed_ret  = $urandom(32'hefcf9e18);
		// busy held high while the stored bit stays low
		pt_busy_i          = 1'b1;
		delayctrl_locked_i = 8'($urandom());
		for (int j = 0; j < N_LINK_WORDS*6; j++) begin
			link_ids[j] = 10'($urandom());
			link_id_i[10*j +: 10] = link_ids[j];
		end
		for (int j = 0; j < N_AF_WORDS*8; j++) begin
			bc0_counts[j] = 8'($urandom());
			bc0_time_counts_i[8*j +: 8] = bc0_counts[j];
		end
		for (int j = 0; j < N_RATE_WORDS*2; j++) begin
			rates[j] = 26'($urandom());
			rates_i[26*j +: 26] = rates[j];
		end
		build_table();
		max_cycles = tbl_cs.size() + 2 + 10;

		repeat (2) @(posedge control_clk);
		rst_i <= 1'b0;
		for (int i = 0; i <= tbl_cs.size(); i++) begin
			@(posedge control_clk);
			if (i < tbl_cs.size()) begin
				cs_i            <= tbl_cs[i];
				we_i            <= tbl_we[i];
				{sel_i, addr_i} <= tbl_addr[i];
				wdata_i         <= tbl_wdata[i];
			end else begin
				cs_i <= 1'b0;
				we_i <= 1'b0;
			end
			// expected values trail the request by the read latency
			if (i > 0) begin
				active    <= 1'b1;
				chk       <= tbl_chk[i-1];
				exp_rdata <= tbl_exp[i-1];
				exp_af    <= tbl_af[i-1];
				exp_cfg   <= tbl_cfg[i-1];
			end
		end
		@(posedge control_clk);
		active <= 1'b0;
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	always @(posedge control_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire
